// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --assert -Wno-fatal
TOP = retireTb
FILELIST = list.f
PASS = All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir

// File: commit/commitStage.sv
`timescale 1ns/1ps

module commitStage import retirePkg::*; (
	input  logic                empty,
	input  logic [63:0]         headPc,
	input  logic [4:0]          headRd,
	input  logic [slotBits-1:0] headSlot,
	input  logic [7:0]          headFlags,
	input  logic                headWritten,
	input  logic                isMisPredict,
	input  logic                lsuFault,
	input  logic [63:0]         mstatusQ,
	input  logic [63:0]         mieQ,
	input  logic [63:0]         mipQ,
	input  logic [63:0]         mepcQ,
	input  logic [63:0]         mtvecQ,
	output logic                pop,
	output logic                commitValid,
	output logic                commitAbort,
	output logic                isTrap,
	output logic                isXRet,
	output logic [63:0]         redirectPc,
	output logic [63:0]         trapMcause,
	output logic [63:0]         trapMepc,
	output logic [63:0]         trapMstatus,
	output logic [63:0]         xretMstatus
);

	logic isBranch, isLoad, isStore, isEcall;
	logic isEbreak, isMret, isIllegal, isInstrFault;
	logic extOn, timerOn, softOn;
	logic loadFault, storeFault;
	logic irqTaken, excTaken, trapTaken, xretTaken;

	// Flag order matches the packing at the top level
	assign {isBranch, isLoad, isStore, isEcall,
		isEbreak, isMret, isIllegal, isInstrFault} = headFlags;

	// Interrupt enabled when pending, unmasked and MIE set
	// mip/mie bit index equals the interrupt code
	assign extOn = mipQ[11] & mieQ[11] & mstatusQ[mieBit];
	assign timerOn = mipQ[7] & mieQ[7] & mstatusQ[mieBit];
	assign softOn = mipQ[3] & mieQ[3] & mstatusQ[mieBit];
	assign irqTaken = extOn | timerOn | softOn;

	// LSU fault only counts before write-back
	assign loadFault = lsuFault & isLoad & ~headWritten;
	assign storeFault = lsuFault & isStore & ~headWritten;
	assign excTaken = isEcall | isEbreak | isIllegal | isInstrFault | loadFault | storeFault;

	assign trapTaken = ~empty & (irqTaken | excTaken);
	// Trap wins over mret on the same head
	assign xretTaken = ~empty & isMret & ~trapTaken;
	assign isTrap = trapTaken;
	assign isXRet = xretTaken;

	assign commitAbort = ~empty & ((isBranch & headWritten & isMisPredict) | isMret | trapTaken);
	// Retire needs write-back and no abort
	assign commitValid = ~empty & headWritten & ~commitAbort;
	assign pop = commitValid;

	// Mispredict target comes from the branch unit, not here
	assign redirectPc = trapTaken ? mtvecQ : (xretTaken ? mepcQ : '0);

	// Fixed cause priority
	always_comb begin
		if (extOn) trapMcause = causeExtIrq;
		else if (softOn) trapMcause = causeSoftIrq;
		else if (timerOn) trapMcause = causeTimerIrq;
		else if (isInstrFault) trapMcause = causeInstrFault;
		else if (isIllegal) trapMcause = causeIllegal;
		else if (isEbreak) trapMcause = causeBreak;
		else if (isEcall) trapMcause = causeEcall;
		else if (loadFault) trapMcause = causeLoadFault;
		else if (storeFault) trapMcause = causeStoreFault;
		else trapMcause = '0;
	end

	// Interrupted or faulting pc both point at the head
	assign trapMepc = headPc;

	// Trap entry: stash MIE into MPIE, disable, MPP to machine
	always_comb begin
		trapMstatus = mstatusQ;
		trapMstatus[mpieBit] = mstatusQ[mieBit];
		trapMstatus[mieBit] = 1'b0;
		trapMstatus[mppLow +: 2] = 2'b11;
	end

	// mret: restore MIE, MPIE back to one
	always_comb begin
		xretMstatus = mstatusQ;
		xretMstatus[mieBit] = mstatusQ[mpieBit];
		xretMstatus[mpieBit] = 1'b1;
	end

endmodule

// File: commit/reorderFifo.sv
`timescale 1ns/1ps

module reorderFifo import retirePkg::*; (
	input  logic                CLK,
	input  logic                reset,
	input  logic                pushValid,
	output logic                pushReady,
	input  logic [63:0]         pushPc,
	input  logic [4:0]          pushRd,
	input  logic [slotBits-1:0] pushSlot,
	input  logic [7:0]          pushFlags,
	input  logic                pop,
	input  logic                flush,
	output logic                empty,
	output logic [63:0]         headPc,
	output logic [4:0]          headRd,
	output logic [slotBits-1:0] headSlot,
	output logic [7:0]          headFlags
);

	// Entry storage, one array per field
	logic [63:0] pcMem [robDepth];
	logic [4:0] rdMem [robDepth];
	logic [slotBits-1:0] slotMem [robDepth];
	logic [7:0] flagMem [robDepth];

	logic [robPtrBits-1:0] rdPtr;
	logic [robPtrBits-1:0] wrPtr;
	// One extra bit to tell full from empty
	logic [robPtrBits:0] count;
	logic pushFire;
	logic popFire;

	// Back-pressure while full
	assign pushReady = (count != (robPtrBits + 1)'(robDepth));
	assign empty = (count == '0);
	// Flush drops a same-cycle push
	assign pushFire = pushValid & pushReady & ~flush;
	assign popFire = pop & ~empty;

	always_ff @(posedge CLK) begin
		if (pushFire) begin
			pcMem[wrPtr] <= pushPc;
			rdMem[wrPtr] <= pushRd;
			slotMem[wrPtr] <= pushSlot;
			flagMem[wrPtr] <= pushFlags;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			// Pointers wrap naturally at robDepth
			if (pushFire) wrPtr <= wrPtr + 1'b1;
			if (popFire) rdPtr <= rdPtr + 1'b1;
			case ({pushFire, popFire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head fields straight from the read pointer
	assign headPc = pcMem[rdPtr];
	assign headRd = rdMem[rdPtr];
	assign headSlot = slotMem[rdPtr];
	assign headFlags = flagMem[rdPtr];

endmodule

// File: common/retirePkg.sv
package retirePkg;

	// Rename slot sizing
	localparam int slotBits = 2;
	localparam int slotCount = 4;

	// Reorder buffer sizing
	localparam int robDepth = 8;
	localparam int robPtrBits = 3;

	// APB byte address of each low word
	// High word sits 0x20 above
	localparam logic [31:0] csrAddrMstatus = 32'h00;
	localparam logic [31:0] csrAddrMie = 32'h04;
	localparam logic [31:0] csrAddrMtvec = 32'h08;
	localparam logic [31:0] csrAddrMepc = 32'h0C;
	localparam logic [31:0] csrAddrMcause = 32'h10;
	localparam logic [31:0] csrAddrMip = 32'h14;

	// Synchronous exception codes
	localparam logic [63:0] causeInstrFault = 64'd1;
	localparam logic [63:0] causeIllegal = 64'd2;
	localparam logic [63:0] causeBreak = 64'd3;
	localparam logic [63:0] causeLoadFault = 64'd5;
	localparam logic [63:0] causeStoreFault = 64'd7;
	localparam logic [63:0] causeEcall = 64'd11;

	// Interrupt codes, bit 63 flags an interrupt
	localparam logic [63:0] causeSoftIrq = {1'b1, 63'd3};
	localparam logic [63:0] causeTimerIrq = {1'b1, 63'd7};
	localparam logic [63:0] causeExtIrq = {1'b1, 63'd11};

	// mstatus field positions
	localparam int mieBit = 3;
	localparam int mpieBit = 7;
	localparam int mppLow = 11;

endpackage

// File: list.f
common/retirePkg.sv
commit/reorderFifo.sv
commit/commitStage.sv
verilog/renameState.sv
verilog/machineCsr.sv
verilog/retireCore.sv
verif/retireCore_checker.sv
verif/retireTb.sv

// File: verif/retireCore_checker.sv
`timescale 1ns/1ps

module retireCore_checker (
	input logic CLK,
	input logic reset,
	input logic commitValid,
	input logic commitAbort,
	input logic isTrap,
	input logic isXRet,
	input logic PSEL,
	input logic PENABLE,
	input logic PREADY,
	input logic dispatchValid,
	input logic dispatchReady
);

	// Retire and abort exclude each other
	assert property (@(posedge CLK) disable iff (reset) !(commitValid && commitAbort))
		else $error("commitValid and commitAbort high together");

	assert property (@(posedge CLK) disable iff (reset) !(isTrap && isXRet))
		else $error("isTrap and isXRet high together");

	// No wait states in the access phase
	assert property (@(posedge CLK) disable iff (reset) (PSEL && PENABLE) |-> PREADY)
		else $error("PREADY low in APB access phase");

	// A full buffer with no retire stays full, so the offered entry was not taken
	assert property (@(posedge CLK) disable iff (reset)
		(dispatchValid && !dispatchReady && !commitValid && !commitAbort) |=> !dispatchReady)
		else $error("dispatch accepted while dispatchReady low");

endmodule

bind retireCore retireCore_checker chk (.*);

// File: verif/retireTb.sv
`timescale 1ns/1ps

module retireTb import retirePkg::*; ();

	localparam int decRetire = 0;
	localparam int decAbort = 1;
	localparam int decTrap = 2;
	localparam int decXret = 3;

	typedef struct {
		logic [63:0] pc;
		logic [4:0] rd;
		logic [1:0] slot;
		logic [7:0] flags;
		int delay;
		logic mis;
		logic lsu;
		int dec;
		logic [63:0] cause;
	} rowT;

	logic CLK = 0, reset = 1;
	logic dispatchValid = 0, wbValid = 0, isMisPredict = 0, lsuFault = 0;
	logic [63:0] dispatchPc = '0;
	logic [4:0] dispatchRd = '0, wbRd = '0;
	logic [slotBits-1:0] dispatchSlot = '0, wbSlot = '0;
	logic [7:0] flags = '0;
	logic extIrq = 0, timerIrq = 0, softIrq = 0;
	logic PSEL = 0, PENABLE = 0, PWRITE = 0;
	logic [31:0] PADDR = '0, PWDATA = '0;
	logic [31:0] PRDATA;
	logic PREADY, PSLVERR, dispatchReady, commitValid, commitAbort, isTrap, isXRet;
	logic [63:0] commitPc, redirectPc;
	// Reference CSR state
	logic [63:0] mMstatus = '0, mMepc = '0, mMcause = '0, mMtvec = '0;
	int errors = 0;
	rowT rows [11];

	retireCore uut (
		.CLK, .reset, .dispatchValid, .dispatchReady, .dispatchPc, .dispatchRd, .dispatchSlot,
		.isBranch(flags[7]), .isLoad(flags[6]), .isStore(flags[5]), .isEcall(flags[4]),
		.isEbreak(flags[3]), .isMret(flags[2]), .isIllegal(flags[1]), .isInstrFault(flags[0]),
		.wbValid, .wbRd, .wbSlot, .isMisPredict, .lsuFault, .extIrq, .timerIrq, .softIrq,
		.PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA, .PREADY, .PSLVERR,
		.commitValid, .commitPc, .commitAbort, .isTrap, .isXRet, .redirectPc
	);

	always #10 CLK = ~CLK;

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			errors++;
			$display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// Setup on one falling edge, access on the next, data sampled just after
	task automatic apbAccess(input logic wr, input logic [31:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err);
		@(negedge CLK);
		PSEL = 1;
		PENABLE = 0;
		PWRITE = wr;
		PADDR = addr;
		PWDATA = data;
		@(negedge CLK);
		PENABLE = 1;
		#1;
		rdata = PRDATA;
		err = PSLVERR;
		@(negedge CLK);
		PSEL = 0;
		PENABLE = 0;
	endtask

	task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] d;
		logic e;
		apbAccess(1, addr, data, d, e);
		check("PSLVERR", 0, e);
	endtask

	task automatic apbCheck(input string name, input logic [31:0] addr, input logic [31:0] exp);
		logic [31:0] d;
		logic e;
		apbAccess(0, addr, '0, d, e);
		check(name, exp, d);
	endtask

	task automatic checkTrapCsrs();
		apbCheck("mcause lo", csrAddrMcause, mMcause[31:0]);
		apbCheck("mcause hi", csrAddrMcause + 32'h20, mMcause[63:32]);
		apbCheck("mepc", csrAddrMepc, mMepc[31:0]);
		apbCheck("mstatus", csrAddrMstatus, mMstatus[31:0]);
	endtask

	// One instruction into an empty buffer, then wait for its commit decision
	task automatic runInstr(input rowT r);
		int t;
		int dec;
		logic found;
		@(negedge CLK);
		dispatchValid = 1;
		dispatchPc = r.pc;
		dispatchRd = r.rd;
		dispatchSlot = r.slot;
		flags = r.flags;
		isMisPredict = r.mis;
		lsuFault = r.lsu;
		t = 0;
		while (!dispatchReady && t < 50) begin
			@(negedge CLK);
			t++;
		end
		if (!dispatchReady) begin
			errors++;
			$display("Timeout: dispatchReady never rose for pc %h", r.pc);
		end
		t = 0;
		found = 0;
		dec = -1;
		while (!found && t < 50) begin
			@(negedge CLK);
			dispatchValid = 0;
			wbValid = 0;
			if (commitValid || commitAbort) begin
				found = 1;
				dec = commitValid ? decRetire : isTrap ? decTrap : isXRet ? decXret : decAbort;
			end else begin
				t++;
				wbValid = (r.delay != 0 && t == r.delay);
				wbRd = r.rd;
				wbSlot = r.slot;
			end
		end
		if (!found) begin
			errors++;
			$display("Timeout: no commit decision for pc %h", r.pc);
		end
		check("decision", r.dec, dec);
		if (dec == decRetire) check("commitPc", r.pc, commitPc);
		if (dec == decTrap) begin
			check("redirectPc", mMtvec, redirectPc);
			mMstatus[mpieBit] = mMstatus[mieBit];
			mMstatus[mieBit] = 0;
			mMstatus[mppLow +: 2] = 2'b11;
			mMepc = r.pc;
			mMcause = r.cause;
		end
		if (dec == decXret) begin
			check("redirectPc", mMepc, redirectPc);
			mMstatus[mieBit] = mMstatus[mpieBit];
			mMstatus[mpieBit] = 1;
		end
		@(negedge CLK);
		isMisPredict = 0;
		lsuFault = 0;
		if (dec == decTrap || dec == decXret) checkTrapCsrs();
	endtask

	// Mispredicted branch with a younger entry behind it that is already written back
	task automatic squashYounger();
		int t;
		@(negedge CLK);
		dispatchValid = 1;
		dispatchPc = 64'h1100;
		dispatchRd = 2;
		dispatchSlot = 3;
		flags = 8'h80;
		isMisPredict = 1;
		@(negedge CLK);
		// Committed slot of x1, retires at once if it ever reaches the head
		dispatchPc = 64'h1104;
		dispatchRd = 1;
		dispatchSlot = 1;
		flags = 8'h00;
		@(negedge CLK);
		dispatchValid = 0;
		wbValid = 1;
		wbRd = 2;
		wbSlot = 3;
		t = 0;
		while (!commitAbort && !commitValid && t < 20) begin
			@(negedge CLK);
			wbValid = 0;
			t++;
		end
		if (!commitAbort) begin
			errors++;
			$display("Timeout: mispredicted branch never aborted");
		end
		check("commitValid at abort", 0, commitValid);
		@(negedge CLK);
		isMisPredict = 0;
		check("commitValid after flush", 0, commitValid);
		check("commitAbort after flush", 0, commitAbort);
	endtask

	// Fill all entries, write back in reverse order, expect in-order retire
	task automatic fillAndDrain();
		int t;
		int k;
		for (k = 0; k < 8; k++) begin
			@(negedge CLK);
			dispatchValid = 1;
			dispatchPc = 64'h2000 + 64'(4 * k);
			dispatchRd = 5'(10 + k);
			dispatchSlot = 1;
			flags = 0;
		end
		@(negedge CLK);
		dispatchPc = 64'h2020;
		dispatchRd = 20;
		for (k = 0; k < 3; k++) begin
			check("dispatchReady full", 0, dispatchReady);
			@(negedge CLK);
		end
		for (k = 7; k >= 0; k--) begin
			check("commitValid early", 0, commitValid);
			wbValid = 1;
			wbRd = 5'(10 + k);
			wbSlot = 1;
			if (k == 0) dispatchValid = 0;
			@(negedge CLK);
			wbValid = 0;
		end
		for (k = 0; k < 8; k++) begin
			t = 0;
			while (!commitValid && t < 20) begin
				@(negedge CLK);
				t++;
			end
			if (!commitValid) begin
				errors++;
				$display("Timeout: entry %0d of the full buffer never retired", k);
			end
			check("commitPc", 64'h2000 + 64'(4 * k), commitPc);
			@(negedge CLK);
			check("dispatchReady drain", 1, dispatchReady);
		end
	endtask

	initial begin
		logic [31:0] d;
		logic e;
		rows[0] = '{64'h1000, 1, 1, 8'h00, 2, 0, 0, decRetire, 0};
		// Same slot already committed and written
		rows[1] = '{64'h1004, 1, 1, 8'h00, 0, 0, 0, decRetire, 0};
		rows[2] = '{64'h1008, 2, 1, 8'h80, 1, 1, 0, decAbort, 0};
		rows[3] = '{64'h100c, 2, 2, 8'h80, 3, 0, 0, decRetire, 0};
		rows[4] = '{64'h1010, 3, 1, 8'h10, 0, 0, 0, decTrap, causeEcall};
		// MPIE still holds the MIE from before the ecall
		rows[5] = '{64'h1014, 9, 1, 8'h04, 0, 0, 0, decXret, 0};
		rows[6] = '{64'h1018, 4, 1, 8'h08, 0, 0, 0, decTrap, causeBreak};
		rows[7] = '{64'h101c, 5, 1, 8'h02, 0, 0, 0, decTrap, causeIllegal};
		rows[8] = '{64'h1020, 6, 1, 8'h01, 0, 0, 0, decTrap, causeInstrFault};
		rows[9] = '{64'h1024, 7, 1, 8'h40, 0, 0, 1, decTrap, causeLoadFault};
		rows[10] = '{64'h1028, 8, 1, 8'h20, 0, 0, 1, decTrap, causeStoreFault};
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		reset = 0;
		check("dispatchReady reset", 1, dispatchReady);
		check("commitValid reset", 0, commitValid);
		check("commitAbort reset", 0, commitAbort);
		check("isTrap reset", 0, isTrap);
		check("isXRet reset", 0, isXRet);
		apbWrite(csrAddrMtvec, 32'h0000_0100);
		mMtvec = 64'h100;
		apbWrite(csrAddrMstatus, 32'h8);
		mMstatus = 64'h8;
		foreach (rows[i]) runInstr(rows[i]);
		squashYounger();
		fillAndDrain();
		// Pending but globally masked
		apbWrite(csrAddrMie, 32'h888);
		softIrq = 1;
		runInstr('{64'h3000, 21, 1, 8'h00, 1, 0, 0, decRetire, 0});
		extIrq = 1;
		apbWrite(csrAddrMstatus, mMstatus[31:0] | 32'h8);
		mMstatus[mieBit] = 1;
		runInstr('{64'h3004, 22, 1, 8'h00, 4, 0, 0, decTrap, causeExtIrq});
		// Software beats timer once external is gone
		extIrq = 0;
		timerIrq = 1;
		apbWrite(csrAddrMstatus, mMstatus[31:0] | 32'h8);
		mMstatus[mieBit] = 1;
		runInstr('{64'h3008, 23, 1, 8'h00, 4, 0, 0, decTrap, causeSoftIrq});
		softIrq = 0;
		apbWrite(csrAddrMstatus, mMstatus[31:0] | 32'h8);
		mMstatus[mieBit] = 1;
		runInstr('{64'h300c, 24, 1, 8'h00, 4, 0, 0, decTrap, causeTimerIrq});
		timerIrq = 0;
		apbAccess(0, 32'h18, '0, d, e);
		check("PSLVERR unmapped", 1, e);
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: verilog/machineCsr.sv
`timescale 1ns/1ps

module machineCsr import retirePkg::*; (
	input  logic        CLK,
	input  logic        reset,
	input  logic        PSEL,
	input  logic        PENABLE,
	input  logic        PWRITE,
	input  logic [31:0] PADDR,
	input  logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic        PREADY,
	output logic        PSLVERR,
	input  logic        extIrq,
	input  logic        timerIrq,
	input  logic        softIrq,
	input  logic        isTrap,
	input  logic        isXRet,
	input  logic [63:0] trapMcause,
	input  logic [63:0] trapMepc,
	input  logic [63:0] trapMstatus,
	input  logic [63:0] xretMstatus,
	output logic [63:0] mstatusQ,
	output logic [63:0] mieQ,
	output logic [63:0] mipQ,
	output logic [63:0] mepcQ,
	output logic [63:0] mtvecQ
);

	logic [63:0] mcauseQ;
	logic [31:0] csrBase;
	logic hiHalf;
	logic addrHit;
	logic apbAccess;
	logic apbWrite;
	logic [63:0] readWord;

	// Replace one 32-bit half of a CSR
	function automatic logic [63:0] mergeHalf(input logic [63:0] oldVal, input logic hi,
		input logic [31:0] data);
		mergeHalf = hi ? {data, oldVal[31:0]} : {oldVal[63:32], data};
	endfunction

	// Bit 5 picks the high word
	assign hiHalf = PADDR[5];
	assign csrBase = {PADDR[31:6], 1'b0, PADDR[4:0]};

	always_comb begin
		addrHit = 1'b1;
		case (csrBase)
			csrAddrMstatus: readWord = mstatusQ;
			csrAddrMie: readWord = mieQ;
			csrAddrMtvec: readWord = mtvecQ;
			csrAddrMepc: readWord = mepcQ;
			csrAddrMcause: readWord = mcauseQ;
			csrAddrMip: readWord = mipQ;
			default: begin
				addrHit = 1'b0;
				readWord = '0;
			end
		endcase
	end

	// No wait states
	assign PREADY = 1'b1;
	assign PRDATA = hiHalf ? readWord[63:32] : readWord[31:0];
	assign apbAccess = PSEL & PENABLE;
	assign PSLVERR = apbAccess & ~addrHit;
	// mip decodes but ignores writes
	assign apbWrite = apbAccess & PWRITE & addrHit;

	always_ff @(posedge CLK) begin
		if (reset) begin
			mstatusQ <= '0;
			mieQ <= '0;
			mipQ <= '0;
			mepcQ <= '0;
			mcauseQ <= '0;
			mtvecQ <= '0;
		end else begin
			// Pending lines land one cycle late
			mipQ <= {52'b0, extIrq, 3'b0, timerIrq, 3'b0, softIrq, 3'b0};
			if (apbWrite && csrBase == csrAddrMie) mieQ <= mergeHalf(mieQ, hiHalf, PWDATA);
			if (apbWrite && csrBase == csrAddrMtvec) mtvecQ <= mergeHalf(mtvecQ, hiHalf, PWDATA);
			// Trap and mret beat software writes
			if (isTrap) begin
				mstatusQ <= trapMstatus;
				mepcQ <= trapMepc;
				mcauseQ <= trapMcause;
			end else begin
				if (isXRet) mstatusQ <= xretMstatus;
				else if (apbWrite && csrBase == csrAddrMstatus)
					mstatusQ <= mergeHalf(mstatusQ, hiHalf, PWDATA);
				if (apbWrite && csrBase == csrAddrMepc) mepcQ <= mergeHalf(mepcQ, hiHalf, PWDATA);
				if (apbWrite && csrBase == csrAddrMcause)
					mcauseQ <= mergeHalf(mcauseQ, hiHalf, PWDATA);
			end
		end
	end

endmodule

// File: verilog/renameState.sv
`timescale 1ns/1ps

module renameState import retirePkg::*; (
	input  logic                CLK,
	input  logic                reset,
	input  logic                wbValid,
	input  logic [4:0]          wbRd,
	input  logic [slotBits-1:0] wbSlot,
	input  logic                retire,
	input  logic [4:0]          retireRd,
	input  logic [slotBits-1:0] retireSlot,
	input  logic                flush,
	input  logic [4:0]          headRd,
	input  logic [slotBits-1:0] headSlot,
	output logic                headWritten
);

	// Committed slot of each architectural register
	logic [slotBits-1:0] archSlot [32];
	// Written-back slots per register
	logic [slotCount-1:0] wbLog [32];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int r = 0; r < 32; r++) begin
				archSlot[r] <= '0;
				// Slot 0 holds the reset value, counts as written
				wbLog[r] <= slotCount'(1);
			end
		end else if (flush) begin
			// Squashed slots drop out, committed ones stay
			for (int r = 0; r < 32; r++) begin
				wbLog[r] <= slotCount'(1) << archSlot[r];
			end
		end else begin
			if (wbValid) begin
				wbLog[wbRd][wbSlot] <= 1'b1;
			end
			if (retire) begin
				archSlot[retireRd] <= retireSlot;
				// Old committed slot becomes free
				if (archSlot[retireRd] != retireSlot) begin
					wbLog[retireRd][archSlot[retireRd]] <= 1'b0;
				end
			end
		end
	end

	// Head lookup for commit
	assign headWritten = wbLog[headRd][headSlot];

endmodule

// File: verilog/retireCore.sv
`timescale 1ns/1ps

module retireCore import retirePkg::*; (
	input  logic                CLK,
	input  logic                reset,
	// Dispatch
	input  logic                dispatchValid,
	output logic                dispatchReady,
	input  logic [63:0]         dispatchPc,
	input  logic [4:0]          dispatchRd,
	input  logic [slotBits-1:0] dispatchSlot,
	input  logic                isBranch,
	input  logic                isLoad,
	input  logic                isStore,
	input  logic                isEcall,
	input  logic                isEbreak,
	input  logic                isMret,
	input  logic                isIllegal,
	input  logic                isInstrFault,
	// Write-back
	input  logic                wbValid,
	input  logic [4:0]          wbRd,
	input  logic [slotBits-1:0] wbSlot,
	// Execution outcome at the head
	input  logic                isMisPredict,
	input  logic                lsuFault,
	// Interrupt lines
	input  logic                extIrq,
	input  logic                timerIrq,
	input  logic                softIrq,
	// APB slave
	input  logic                PSEL,
	input  logic                PENABLE,
	input  logic                PWRITE,
	input  logic [31:0]         PADDR,
	input  logic [31:0]         PWDATA,
	output logic [31:0]         PRDATA,
	output logic                PREADY,
	output logic                PSLVERR,
	// Commit results
	output logic                commitValid,
	output logic [63:0]         commitPc,
	output logic                commitAbort,
	output logic                isTrap,
	output logic                isXRet,
	output logic [63:0]         redirectPc
);

	logic pop, empty, headWritten;
	logic [4:0] headRd;
	logic [slotBits-1:0] headSlot;
	logic [7:0] headFlags;
	logic [63:0] mstatusQ, mieQ, mipQ, mepcQ, mtvecQ;
	logic [63:0] trapMcause, trapMepc, trapMstatus, xretMstatus;

	// Head pc is the retiring pc
	reorderFifo fifo (
		.CLK(CLK), .reset(reset),
		.pushValid(dispatchValid), .pushReady(dispatchReady),
		.pushPc(dispatchPc), .pushRd(dispatchRd), .pushSlot(dispatchSlot),
		.pushFlags({isBranch, isLoad, isStore, isEcall, isEbreak, isMret, isIllegal, isInstrFault}),
		.pop(pop), .flush(commitAbort), .empty(empty),
		.headPc(commitPc), .headRd(headRd), .headSlot(headSlot), .headFlags(headFlags)
	);

	// Retire commits the head's rd and slot
	renameState rename (
		.CLK(CLK), .reset(reset),
		.wbValid(wbValid), .wbRd(wbRd), .wbSlot(wbSlot),
		.retire(commitValid), .retireRd(headRd), .retireSlot(headSlot),
		.flush(commitAbort), .headRd(headRd), .headSlot(headSlot),
		.headWritten(headWritten)
	);

	commitStage commit (
		.empty(empty), .headPc(commitPc), .headRd(headRd), .headSlot(headSlot),
		.headFlags(headFlags), .headWritten(headWritten),
		.isMisPredict(isMisPredict), .lsuFault(lsuFault),
		.mstatusQ(mstatusQ), .mieQ(mieQ), .mipQ(mipQ), .mepcQ(mepcQ), .mtvecQ(mtvecQ),
		.pop(pop), .commitValid(commitValid), .commitAbort(commitAbort),
		.isTrap(isTrap), .isXRet(isXRet), .redirectPc(redirectPc),
		.trapMcause(trapMcause), .trapMepc(trapMepc),
		.trapMstatus(trapMstatus), .xretMstatus(xretMstatus)
	);

	machineCsr csr (
		.CLK(CLK), .reset(reset),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA),
		.PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
		.extIrq(extIrq), .timerIrq(timerIrq), .softIrq(softIrq),
		.isTrap(isTrap), .isXRet(isXRet), .trapMcause(trapMcause), .trapMepc(trapMepc),
		.trapMstatus(trapMstatus), .xretMstatus(xretMstatus),
		.mstatusQ(mstatusQ), .mieQ(mieQ), .mipQ(mipQ), .mepcQ(mepcQ), .mtvecQ(mtvecQ)
	);

endmodule
